// File: Makefile
VERILATOR ?= verilator
TOP ?= apb_subsys_tb
OBJ_DIR ?= obj_dir
FILELIST ?= filelist.f
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal -j 0
RUN_ARGS ?= +verilator+error+limit+1000

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "Simulation stopped without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+src
src/apb_types_pkg.sv
src/apb_fsm_pkg.sv
src/apb_bus_if.sv
src/apb_requester.sv
src/apb_arbiter.sv
src/apb_reg_slave.sv
src/apb_bus_monitor.sv
src/apb_subsys_top.sv
sim/apb_subsys_assertions.sv
sim/apb_subsys_tb.sv

// File: sim/apb_subsys_assertions.sv
// APB subsystem assertions
`timescale 1ns/1ps

module apb_subsys_assertions (
	input logic PCLK,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input apb_types_pkg::addr_t paddr,
	input logic pwrite,
	input apb_types_pkg::data_t pwdata,
	input logic [1:0] busy,
	input logic [1:0] done
);

	// Raised by any failing assertion, watched by the testbench every cycle
	bit fired = 1'b0;

	//////////////////////////////
	// Bus handshake
	//////////////////////////////

	// Setup is always followed by access
	setup_then_access: assert property (@(posedge PCLK) disable iff (rst)
		psel && !penable |=> psel && penable)
		else
		begin
			fired = 1'b1;
			$error("Setup phase not followed by access phase");
		end

	// Command held while the slave stalls
	stall_cmd_stable: assert property (@(posedge PCLK) disable iff (rst)
		psel && penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else
		begin
			fired = 1'b1;
			$error("Command changed during a stall");
		end

	//////////////////////////////
	// Requester ports
	//////////////////////////////

	// Done is a single-cycle pulse
	done0_single: assert property (@(posedge PCLK) disable iff (rst) done[0] |=> !done[0])
		else
		begin
			fired = 1'b1;
			$error("Port 0 done wider than one cycle");
		end

	done1_single: assert property (@(posedge PCLK) disable iff (rst) done[1] |=> !done[1])
		else
		begin
			fired = 1'b1;
			$error("Port 1 done wider than one cycle");
		end

	// Idle ports and bus straight out of reset
	reset_idle: assert property (@(posedge PCLK) rst |=> busy == 2'b00 && !psel)
		else
		begin
			fired = 1'b1;
			$error("Busy or PSEL high after reset");
		end

endmodule

bind apb_subsys_top apb_subsys_assertions i_assertions (
	.PCLK(PCLK),
	.rst(rst),
	.psel(apb_bus.psel),
	.penable(apb_bus.penable),
	.pready(apb_bus.pready),
	.paddr(apb_bus.paddr),
	.pwrite(apb_bus.pwrite),
	.pwdata(apb_bus.pwdata),
	.busy({busy1, busy0}),
	.done({done1, done0})
);

// File: sim/apb_subsys_tb.sv
// APB subsystem testbench
`timescale 1ns/1ps

module apb_subsys_tb;

	localparam int N_XFERS = 400;
	// Generous per-transfer budget
	localparam int TIMEOUT_CYCLES = N_XFERS * 20;
	localparam logic [31:0] SEED = 32'hc71a_a4bd;
	// Shortest req to done distance in cycles
	localparam int MIN_LATENCY = 4;

	logic PCLK;
	logic rst;
	logic [1:0] req;
	apb_types_pkg::addr_t addr [2];
	logic [1:0] write;
	apb_types_pkg::data_t wdata [2];
	logic [1:0] busy;
	logic [1:0] done;
	apb_types_pkg::data_t rdata [2];
	logic [1:0] slverr;
	logic proto_err;

	// Reference register file and stimulus bookkeeping
	apb_types_pkg::data_t model_regs [8];
	logic [31:0] lfsr;
	int cycle_cnt = 0;
	int issued;
	int completed;
	bit stim_on;
	bit [1:0] pend;
	apb_types_pkg::addr_t cmd_addr [2];
	logic [1:0] cmd_write;
	apb_types_pkg::data_t cmd_wdata [2];
	int issue_cycle [2];

	apb_subsys_top i_apb_subsys_top (
		.PCLK(PCLK), .rst(rst),
		.req0(req[0]), .addr0(addr[0]), .write0(write[0]), .wdata0(wdata[0]),
		.busy0(busy[0]), .done0(done[0]), .rdata0(rdata[0]), .slverr0(slverr[0]),
		.req1(req[1]), .addr1(addr[1]), .write1(write[1]), .wdata1(wdata[1]),
		.busy1(busy[1]), .done1(done[1]), .rdata1(rdata[1]), .slverr1(slverr[1]),
		.proto_err(proto_err)
	);

	//////////////////////////////
	// Random source and model
	//////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// Eight words, error from 0x20 up, read data zero on error
	function automatic void model_access(input apb_types_pkg::addr_t a, input logic wr,
		input apb_types_pkg::data_t wd, output apb_types_pkg::data_t exp_rdata,
		output bit exp_err);
		int idx;
		idx = int'(a[4:2]);
		exp_rdata = '0;
		exp_err = (a >= 8'h20);
		if (!exp_err && wr)
			model_regs[idx] = wd;
		else if (!exp_err)
			exp_rdata = model_regs[idx];
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input apb_types_pkg::data_t got,
		input apb_types_pkg::data_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input bit got, input bit exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// One done pulse retires the outstanding command of that port
	task automatic check_done(input int n);
		apb_types_pkg::data_t exp_rdata;
		bit exp_err;
		int lat;
		lat = cycle_cnt - issue_cycle[n] - 1;
		if (!pend[n])
		begin
			$display("Port %0d raised done with no transfer outstanding", n);
			abort_run();
		end
		else if (lat < MIN_LATENCY)
		begin
			$display("Port %0d finished %0d cycles after its request", n, lat);
			abort_run();
		end
		else
		begin
			model_access(cmd_addr[n], cmd_write[n], cmd_wdata[n], exp_rdata, exp_err);
			check_bit(n ? "slverr1" : "slverr0", slverr[n], exp_err);
			// Read data only meaningful for reads and errors
			if (!cmd_write[n] || exp_err)
				check_data(n ? "rdata1" : "rdata0", rdata[n], exp_rdata);
			pend[n] = 1'b0;
			completed++;
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic drive_port(input int n);
		apb_types_pkg::addr_t a;
		if (!pend[n])
		begin
			if (issued < N_XFERS && lfsr_bits(2) != 0)
			begin
				// Word addresses 0x00 to 0x3C, upper half out of range
				a = {2'b00, 4'(lfsr_bits(4)), 2'b00};
				// Same address never outstanding on both ports
				if (!(pend[1 - n] && cmd_addr[1 - n] == a))
				begin
					cmd_addr[n] = a;
					cmd_write[n] = lfsr_bit();
					cmd_wdata[n] = lfsr_bits(32);
					pend[n] = 1'b1;
					issue_cycle[n] = cycle_cnt;
					issued++;
					req[n] <= 1'b1;
					addr[n] <= a;
					write[n] <= cmd_write[n];
					wdata[n] <= cmd_wdata[n];
				end
			end
		end
		else if (lfsr_bits(3) == 0)
		begin
			// Stray pulse while busy, must be ignored
			req[n] <= 1'b1;
			addr[n] <= 8'(lfsr_bits(8));
		end
	endtask

	initial
	begin
		PCLK = 1'b0;
		forever #4 PCLK = ~PCLK;
	end

	always @(posedge PCLK)
		cycle_cnt <= cycle_cnt + 1;

	// Request strobes default low, one-cycle pulses only
	always @(posedge PCLK)
	begin
		req <= 2'b00;
		if (stim_on)
		begin
			for (int n = 0; n < 2; n++)
				drive_port(n);
		end
	end

	// Compare on the falling edge where outputs are settled
	always @(negedge PCLK)
	begin
		if (i_apb_subsys_top.i_assertions.fired)
		begin
			$display("Bound assertions flagged a protocol violation");
			abort_run();
		end
		else if (stim_on)
		begin
			check_bit("proto_err", proto_err, 1'b0);
			for (int n = 0; n < 2; n++)
				if (done[n])
					check_done(n);
		end
	end

	initial
	begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Run did not finish in %0d cycles, %0d of %0d transfers done",
			TIMEOUT_CYCLES, completed, N_XFERS);
		abort_run();
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		lfsr = SEED;
		rst = 1'b1;
		req = 2'b00;
		write = 2'b00;
		addr[0] = '0;
		addr[1] = '0;
		wdata[0] = '0;
		wdata[1] = '0;
		pend = 2'b00;
		issued = 0;
		completed = 0;
		stim_on = 1'b0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;

		// Eight clock edges with reset high
		repeat (7) @(posedge PCLK);
		@(negedge PCLK);
		check_bit("busy0", busy[0], 1'b0);
		check_bit("busy1", busy[1], 1'b0);
		check_bit("done0", done[0], 1'b0);
		check_bit("done1", done[1], 1'b0);
		check_bit("proto_err", proto_err, 1'b0);
		@(posedge PCLK);
		rst <= 1'b0;
		@(negedge PCLK);
		stim_on = 1'b1;

		wait (issued == N_XFERS && pend == 2'b00);
		// Idle tail catches late or extra done pulses
		repeat (10) @(negedge PCLK);
		check_bit("proto_err", proto_err, 1'b0);
		if (i_apb_subsys_top.i_assertions.fired)
		begin
			$display("Bound assertions flagged a protocol violation");
			abort_run();
		end
		else
		begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: src/apb_arbiter.sv
// APB round-robin arbiter
`timescale 1ns/1ps

module apb_arbiter (
	input logic PCLK,
	input logic rst,
	input logic bus_req0,
	input logic bus_req1,
	input apb_types_pkg::addr_t r_addr0,
	input apb_types_pkg::addr_t r_addr1,
	input logic r_write0,
	input logic r_write1,
	input apb_types_pkg::data_t r_wdata0,
	input apb_types_pkg::data_t r_wdata1,
	output logic grant0,
	output logic grant1,
	apb_bus_if.arbiter bus
);

	// One-hot owner, zero while the bus is free
	logic [1:0] own;
	// Access phase flag
	logic access_q;
	// Set when requester 1 won last
	logic last_win;
	logic [1:0] pick;

	//////////////////////////////
	// Owner selection
	//////////////////////////////

	// On a tie the requester that lost last time goes first
	always_comb
	begin
		if (bus_req0 && bus_req1)
			pick = last_win ? 2'b01 : 2'b10;
		else
			pick = {bus_req1, bus_req0};
	end

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			own <= 2'b00;
			access_q <= 1'b0;
			last_win <= 1'b1;
		end
		else if (own == 2'b00)
		begin
			// Free cycle, new owner enters setup next
			own <= pick;
			if (pick != 2'b00)
				last_win <= pick[1];
		end
		else if (!access_q)
			access_q <= 1'b1;
		else if (bus.pready)
		begin
			// Released after the completing access
			own <= 2'b00;
			access_q <= 1'b0;
		end
	end

	//////////////////////////////
	// Bus drive
	//////////////////////////////

	assign grant0 = own[0];
	assign grant1 = own[1];

	assign bus.psel = own[0] | own[1];
	assign bus.penable = access_q;

	// Owner's command, held by the requester under back-pressure
	assign bus.paddr = own[1] ? r_addr1 : r_addr0;
	assign bus.pwrite = own[1] ? r_write1 : r_write0;
	assign bus.pwdata = own[1] ? r_wdata1 : r_wdata0;

endmodule

// File: src/apb_bus_if.sv
// Shared APB bus
`timescale 1ns/1ps

interface apb_bus_if;

	// Master side, driven by the arbiter
	logic psel;
	logic penable;
	apb_types_pkg::addr_t paddr;
	logic pwrite;
	apb_types_pkg::data_t pwdata;

	// Slave side response
	logic pready;
	apb_types_pkg::data_t prdata;
	logic pslverr;

	// Arbiter drives the command
	modport arbiter (
		output psel, penable, paddr, pwrite, pwdata,
		input pready, prdata, pslverr
	);

	// Register file answers
	modport slave (
		input psel, penable, paddr, pwrite, pwdata,
		output pready, prdata, pslverr
	);

	// Passive observer
	modport monitor (
		input psel, penable, paddr, pwrite, pwdata, pready, prdata, pslverr
	);

endinterface

// File: src/apb_bus_monitor.sv
// APB protocol monitor
`timescale 1ns/1ps
`include "apb_macros.svh"

module apb_bus_monitor (
	input logic PCLK,
	input logic rst,
	apb_bus_if.monitor bus,
	output logic proto_err
);

	// Past-cycle copies of the bus
	logic after_rst;
	logic psel_q;
	logic penable_q;
	logic pready_q;
	apb_types_pkg::addr_t paddr_q;
	logic pwrite_q;
	apb_types_pkg::data_t pwdata_q;
	apb_types_pkg::stall_cnt_t stall_cnt;
	logic held;
	logic viol;

	// Setup cycle or stalled access last cycle
	assign held = psel_q && (!penable_q || !pready_q);

	//////////////////////////////
	// Rule checks
	//////////////////////////////

	always_comb
	begin
		viol = 1'b0;
		// PSEL low right after reset
		if (after_rst && bus.psel)
			viol = 1'b1;
		// Fresh select must start with setup
		if (bus.psel && !psel_q && bus.penable)
			viol = 1'b1;
		// Setup or stall must continue into access
		if (held && !(bus.psel && bus.penable))
			viol = 1'b1;
		// Command stable while held
		if (held && (bus.paddr != paddr_q || bus.pwrite != pwrite_q))
			viol = 1'b1;
		if (held && bus.pwrite && bus.pwdata != pwdata_q)
			viol = 1'b1;
		// Stall limit
		if (stall_cnt == apb_types_pkg::stall_cnt_t'(`APB_MAX_STALL))
			viol = 1'b1;
		// Error only with a ready access
		if (bus.pslverr && !(bus.psel && bus.penable && bus.pready))
			viol = 1'b1;
	end

	//////////////////////////////
	// History and sticky flag
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			after_rst <= 1'b1;
			psel_q <= 1'b0;
			penable_q <= 1'b0;
			pready_q <= 1'b0;
			stall_cnt <= '0;
			proto_err <= 1'b0;
		end
		else
		begin
			after_rst <= 1'b0;
			psel_q <= bus.psel;
			penable_q <= bus.penable;
			pready_q <= bus.pready;
			// Counts stalled access cycles, saturates at the limit
			if (!bus.psel || !bus.penable)
				stall_cnt <= '0;
			else if (!bus.pready && stall_cnt != apb_types_pkg::stall_cnt_t'(`APB_MAX_STALL))
				stall_cnt <= stall_cnt + 1'b1;
			proto_err <= proto_err | viol;
		end
	end

	always_ff @(posedge PCLK)
	begin
		paddr_q <= bus.paddr;
		pwrite_q <= bus.pwrite;
		pwdata_q <= bus.pwdata;
	end

endmodule

// File: src/apb_fsm_pkg.sv
// APB state machine encodings
package apb_fsm_pkg;

	// Requester transfer phase
	typedef enum logic [1:0]
	{
		req_idle,
		req_wait_grant,
		req_setup,
		req_access
	} req_state_t;

	// Slave response sequencing
	typedef enum logic [1:0]
	{
		slv_idle,
		slv_stall,
		slv_respond
	} slv_state_t;

endpackage

// File: src/apb_macros.svh
// APB subsystem parameters
`ifndef APB_MACROS_SVH
`define APB_MACROS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Byte address width
`define APB_ADDR_W 8
// Data word width
`define APB_DATA_W 32

//////////////////////////////
// Slave and protocol limits
//////////////////////////////

// Registers in the slave, word addresses 0x00 to 0x1C
`define APB_REG_COUNT 8
// Stall cycles that must never be reached
`define APB_MAX_STALL 4

`endif

// File: src/apb_reg_slave.sv
// APB register file slave
`timescale 1ns/1ps
`include "apb_macros.svh"

module apb_reg_slave (
	input logic PCLK,
	input logic rst,
	apb_bus_if.slave bus
);

	apb_types_pkg::data_t regs [`APB_REG_COUNT];
	apb_fsm_pkg::slv_state_t state;
	apb_types_pkg::stall_cnt_t cnt;
	apb_types_pkg::stall_cnt_t waits;
	apb_types_pkg::reg_idx_t idx;
	logic legal;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// Wait states from word address bits 3 to 2
	assign waits = apb_types_pkg::stall_cnt_t'(bus.paddr[3:2]);
	assign idx = bus.paddr[2 +: $bits(apb_types_pkg::reg_idx_t)];
	// Anything past the last word is an error
	assign legal = bus.paddr < apb_types_pkg::addr_t'(`APB_REG_COUNT * 4);

	//////////////////////////////
	// Wait-state sequencing
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			state <= apb_fsm_pkg::slv_idle;
			cnt <= '0;
		end
		else
		begin
			case (state)
				apb_fsm_pkg::slv_idle:
					// Setup cycle loads the stall count
					if (bus.psel && !bus.penable)
					begin
						cnt <= waits;
						if (waits == '0)
							state <= apb_fsm_pkg::slv_respond;
						else
							state <= apb_fsm_pkg::slv_stall;
					end
				apb_fsm_pkg::slv_stall:
				begin
					cnt <= cnt - 1'b1;
					if (cnt == apb_types_pkg::stall_cnt_t'(1))
						state <= apb_fsm_pkg::slv_respond;
				end
				default:
					state <= apb_fsm_pkg::slv_idle;
			endcase
		end
	end

	//////////////////////////////
	// Register file
	//////////////////////////////

	// Write lands in the ready access cycle
	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			for (int i = 0; i < `APB_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (bus.pready && bus.psel && bus.penable && bus.pwrite && legal)
			regs[idx] <= bus.pwdata;
	end

	assign bus.pready = (state == apb_fsm_pkg::slv_respond);
	// Read data zero on writes and on errors
	assign bus.prdata = (bus.pready && legal && !bus.pwrite) ? regs[idx] : '0;
	assign bus.pslverr = bus.pready && !legal;

endmodule

// File: src/apb_requester.sv
// APB requester port
`timescale 1ns/1ps

module apb_requester (
	input logic PCLK,
	input logic rst,
	input logic req,
	input apb_types_pkg::addr_t addr,
	input logic write,
	input apb_types_pkg::data_t wdata,
	input logic grant,
	input logic pready,
	input apb_types_pkg::data_t prdata,
	input logic pslverr,
	output logic busy,
	output logic done,
	output apb_types_pkg::data_t rdata,
	output logic slverr,
	output logic bus_req,
	output apb_types_pkg::addr_t r_addr,
	output logic r_write,
	output apb_types_pkg::data_t r_wdata
);

	apb_fsm_pkg::req_state_t state;
	apb_fsm_pkg::req_state_t phase;
	apb_fsm_pkg::req_state_t state_nxt;
	logic accept;
	logic finish;

	//////////////////////////////
	// Phase decode
	//////////////////////////////

	// Grant seen while waiting is the setup cycle itself
	always_comb
	begin
		phase = state;
		if (state == apb_fsm_pkg::req_wait_grant && grant)
			phase = apb_fsm_pkg::req_setup;
	end

	// New command only when fully idle, done cycle included
	assign accept = req && !busy;
	// Completing access cycle
	assign finish = (phase == apb_fsm_pkg::req_access) && grant && pready;

	always_comb
	begin
		state_nxt = state;
		case (phase)
			apb_fsm_pkg::req_idle:
				if (accept)
					state_nxt = apb_fsm_pkg::req_wait_grant;
			apb_fsm_pkg::req_setup:
				state_nxt = apb_fsm_pkg::req_access;
			apb_fsm_pkg::req_access:
				if (finish)
					state_nxt = apb_fsm_pkg::req_idle;
			default:
				state_nxt = state;
		endcase
	end

	//////////////////////////////
	// State and handshake
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			state <= apb_fsm_pkg::req_idle;
			done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// Done one cycle after the ready access
			done <= finish;
		end
	end

	// Command latched on accept, stable through setup and access
	always_ff @(posedge PCLK)
	begin
		if (accept)
		begin
			r_addr <= addr;
			r_write <= write;
			r_wdata <= wdata;
		end
	end

	// Response captured in the completing cycle
	always_ff @(posedge PCLK)
	begin
		if (finish)
		begin
			rdata <= prdata;
			slverr <= pslverr;
		end
	end

	// Busy through the done cycle, drops with it
	assign busy = (state != apb_fsm_pkg::req_idle) || done;
	assign bus_req = (state == apb_fsm_pkg::req_wait_grant);

endmodule

// File: src/apb_subsys_top.sv
// APB two-port subsystem
`timescale 1ns/1ps

module apb_subsys_top (
	input logic PCLK,
	input logic rst,
	// Port 0
	input logic req0,
	input apb_types_pkg::addr_t addr0,
	input logic write0,
	input apb_types_pkg::data_t wdata0,
	output logic busy0,
	output logic done0,
	output apb_types_pkg::data_t rdata0,
	output logic slverr0,
	// Port 1
	input logic req1,
	input apb_types_pkg::addr_t addr1,
	input logic write1,
	input apb_types_pkg::data_t wdata1,
	output logic busy1,
	output logic done1,
	output apb_types_pkg::data_t rdata1,
	output logic slverr1,
	// Sticky protocol error
	output logic proto_err
);

	logic bus_req0;
	logic bus_req1;
	logic grant0;
	logic grant1;
	apb_types_pkg::addr_t r_addr0;
	apb_types_pkg::addr_t r_addr1;
	logic r_write0;
	logic r_write1;
	apb_types_pkg::data_t r_wdata0;
	apb_types_pkg::data_t r_wdata1;

	apb_bus_if apb_bus ();

	//////////////////////////////
	// Requesters
	//////////////////////////////

	apb_requester i_req0 (
		.PCLK(PCLK), .rst(rst), .req(req0), .addr(addr0), .write(write0),
		.wdata(wdata0), .grant(grant0), .pready(apb_bus.pready),
		.prdata(apb_bus.prdata), .pslverr(apb_bus.pslverr), .busy(busy0),
		.done(done0), .rdata(rdata0), .slverr(slverr0), .bus_req(bus_req0),
		.r_addr(r_addr0), .r_write(r_write0), .r_wdata(r_wdata0)
	);

	apb_requester i_req1 (
		.PCLK(PCLK), .rst(rst), .req(req1), .addr(addr1), .write(write1),
		.wdata(wdata1), .grant(grant1), .pready(apb_bus.pready),
		.prdata(apb_bus.prdata), .pslverr(apb_bus.pslverr), .busy(busy1),
		.done(done1), .rdata(rdata1), .slverr(slverr1), .bus_req(bus_req1),
		.r_addr(r_addr1), .r_write(r_write1), .r_wdata(r_wdata1)
	);

	//////////////////////////////
	// Shared bus
	//////////////////////////////

	apb_arbiter i_arbiter (
		.PCLK(PCLK), .rst(rst), .bus_req0(bus_req0), .bus_req1(bus_req1),
		.r_addr0(r_addr0), .r_addr1(r_addr1), .r_write0(r_write0),
		.r_write1(r_write1), .r_wdata0(r_wdata0), .r_wdata1(r_wdata1),
		.grant0(grant0), .grant1(grant1), .bus(apb_bus.arbiter)
	);

	apb_reg_slave i_slave (.PCLK(PCLK), .rst(rst), .bus(apb_bus.slave));

	apb_bus_monitor i_monitor (
		.PCLK(PCLK), .rst(rst), .bus(apb_bus.monitor), .proto_err(proto_err)
	);

endmodule

// File: src/apb_types_pkg.sv
// APB data types
`include "apb_macros.svh"

package apb_types_pkg;

	//////////////////////////////
	// Bus payload
	//////////////////////////////

	// Byte address on the bus
	typedef logic [`APB_ADDR_W-1:0] addr_t;

	// Read and write data word
	typedef logic [`APB_DATA_W-1:0] data_t;

	//////////////////////////////
	// Slave and monitor
	//////////////////////////////

	// Register number, taken from word address bits
	typedef logic [$clog2(`APB_REG_COUNT)-1:0] reg_idx_t;

	// Stall counter, wide enough to hold the limit itself
	typedef logic [$clog2(`APB_MAX_STALL+1)-1:0] stall_cnt_t;

endpackage
